/* logic/game_pkg.sv */
`default_nettype none

package game_pkg;

	// ------------------------------------------------------------
	// coordinate and motion types
	// ------------------------------------------------------------
	typedef logic [9:0] coord_t;
	typedef logic signed [9:0] vel_t;
	typedef logic [3:0] fall_t;
	typedef logic [3:0] tile_row_t;
	typedef logic [5:0] tile_col_t;
	typedef logic [7:0] key_t;
	typedef logic [1:0] score_t;

	typedef struct packed {
		tile_row_t row;
		tile_col_t col;
	} tile_cell_t;

	typedef enum logic [1:0] {
		TILE_SKY = 2'd0,
		TILE_BRICK = 2'd1,
		TILE_COIN = 2'd2
	} tile_kind_t;

	// x and y are the bottom-right corner on screen
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t scroll;
		logic face_left;
	} player_state_t;

	// ------------------------------------------------------------
	// level constants
	// ------------------------------------------------------------
	localparam int TILE_SHIFT = 5;
	localparam int MAP_ROWS = 15;
	localparam int MAP_COLS = 60;
	localparam coord_t PLAYER_W = 10'd26;
	localparam coord_t PLAYER_H = 10'd32;
	localparam coord_t SCREEN_MIN_X = 10'd190;
	localparam coord_t SCREEN_MAX_X = 10'd384;
	localparam coord_t SPAWN_X = 10'd228;
	localparam coord_t SPAWN_Y = 10'd33;
	localparam key_t KEY_LEFT = 8'h04;
	localparam key_t KEY_RIGHT = 8'h07;
	localparam int NUM_COINS = 3;

	// coin order matters, first match wins on a touch
	localparam tile_cell_t [0:NUM_COINS-1] COIN_CELLS = '{
		'{row: 4'd7, col: 6'd14},
		'{row: 4'd6, col: 6'd20},
		'{row: 4'd8, col: 6'd30}
	};

	// pixel position to tile cell, rows past the map give row 15 (sky)
	function automatic tile_cell_t cell_of(coord_t wx, coord_t wy);
		tile_cell_t c;
		c.col = tile_col_t'(wx >> TILE_SHIFT);
		if ((wy >> TILE_SHIFT) >= MAP_ROWS)
			c.row = '1;
		else
			c.row = tile_row_t'(wy >> TILE_SHIFT);
		return c;
	endfunction

endpackage

`default_nettype wire

/* logic/video_pkg.sv */
`default_nettype none

package video_pkg;

	typedef logic [23:0] rgb_t;

	// one screen position to colour
	typedef struct packed {
		game_pkg::coord_t draw_x;
		game_pkg::coord_t draw_y;
		logic active;
	} pixel_req_t;

	// registered colour result
	typedef struct packed {
		rgb_t rgb;
		logic valid;
	} pixel_out_t;

	// ------------------------------------------------------------
	// flat colours
	// ------------------------------------------------------------
	localparam rgb_t COLOR_PLAYER = 24'hFF5500;
	localparam rgb_t COLOR_BRICK = 24'h833D00;
	localparam rgb_t COLOR_COIN = 24'hFFC107;
	localparam rgb_t COLOR_SKY = 24'h00007F;
	// blanking interval
	localparam rgb_t COLOR_BLANK = 24'h000000;

endpackage

`default_nettype wire

/* logic/level_map.sv */
`default_nettype none

module level_map (
	input wire [game_pkg::NUM_COINS-1:0] coin_present,
	input wire game_pkg::tile_cell_t [3:0] probe_cells,
	output logic [3:0] probe_solid,
	input wire game_pkg::tile_cell_t render_cell,
	output game_pkg::tile_kind_t render_kind
);

	// ------------------------------------------------------------
	// fixed brick layout
	// ------------------------------------------------------------
	function automatic logic is_brick(game_pkg::tile_cell_t c);
		logic hit;
		hit = 1'b0;
		// ground band
		if (c.row >= 4'd11) begin
			hit = 1'b1;
		end else begin
			case (c.row)
				// lower platform steps
				4'd10: hit = c.col inside {[14:17], [25:28]};
				4'd9: hit = c.col inside {[15:16], [26:28]};
				// pillars and the small ledge
				4'd8: hit = c.col inside {19, 20, 27, 28, 36, 46, 56};
				4'd7: hit = c.col inside {28, 36, 46, 56};
				default: hit = 1'b0;
			endcase
		end
		return hit;
	endfunction

	// bricks first, then any coin still present
	function automatic game_pkg::tile_kind_t kind_of(
		game_pkg::tile_cell_t c,
		logic [game_pkg::NUM_COINS-1:0] present
	);
		game_pkg::tile_kind_t k;
		k = game_pkg::TILE_SKY;
		// anything off the map is sky
		if (c.row < game_pkg::MAP_ROWS && c.col < game_pkg::MAP_COLS) begin
			if (is_brick(c))
				k = game_pkg::TILE_BRICK;
			for (int i = 0; i < game_pkg::NUM_COINS; i++) begin
				if (present[i] && c == game_pkg::COIN_CELLS[i])
					k = game_pkg::TILE_COIN;
			end
		end
		return k;
	endfunction

	// ------------------------------------------------------------
	// lookups
	// ------------------------------------------------------------
	// coins are not solid, only bricks stop the player
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			probe_solid[p] = kind_of(probe_cells[p], coin_present) == game_pkg::TILE_BRICK;
		end
	end

	// renderer port
	assign render_kind = kind_of(render_cell, coin_present);

endmodule

`default_nettype wire

/* logic/player_motion.sv */
`default_nettype none

module player_motion #(
	parameter int max_vx = 4,
	parameter int terminal_fall = 6
) (
	input wire Clk,
	input wire Reset,
	input wire frame_tick,
	input wire game_pkg::key_t key,
	output game_pkg::tile_cell_t [3:0] probe_cells,
	input wire [3:0] probe_solid,
	output game_pkg::player_state_t player
);

	localparam game_pkg::fall_t FALL_MAX = game_pkg::fall_t'(terminal_fall);
	localparam game_pkg::coord_t STEP = game_pkg::coord_t'(max_vx);
	// box extents from the bottom-right corner
	localparam game_pkg::coord_t LEFT_OFS = game_pkg::PLAYER_W - 10'd1;
	localparam game_pkg::coord_t TOP_OFS = game_pkg::PLAYER_H - 10'd1;
	localparam game_pkg::coord_t TILE_W = game_pkg::coord_t'(1 << game_pkg::TILE_SHIFT);

	game_pkg::fall_t fall;
	game_pkg::fall_t fall_next;
	game_pkg::fall_t fall_upd;
	game_pkg::coord_t y_probe;
	game_pkg::coord_t world_x;
	game_pkg::coord_t lead_x;
	game_pkg::coord_t lead_edge;
	game_pkg::coord_t x_target;
	game_pkg::vel_t dx;
	game_pkg::player_state_t player_next;
	logic go_left;
	logic go_right;

	assign go_left = key == game_pkg::KEY_LEFT;
	assign go_right = key == game_pkg::KEY_RIGHT;

	// ------------------------------------------------------------
	// probes
	// ------------------------------------------------------------
	// speed for this frame, capped
	assign fall_next = (fall >= FALL_MAX) ? FALL_MAX : fall + 4'd1;
	assign y_probe = player.y + game_pkg::coord_t'(fall_next);
	assign world_x = player.x + player.scroll;
	// leading column one step out
	assign lead_x = go_left ? world_x - LEFT_OFS - STEP : world_x + STEP;
	assign lead_edge = (lead_x >> game_pkg::TILE_SHIFT) << game_pkg::TILE_SHIFT;

	// 0,1 bottom corners ahead of the fall, 2,3 top and bottom of the leading side
	assign probe_cells[0] = game_pkg::cell_of(world_x - LEFT_OFS, y_probe);
	assign probe_cells[1] = game_pkg::cell_of(world_x, y_probe);
	assign probe_cells[2] = game_pkg::cell_of(lead_x, player.y - TOP_OFS);
	assign probe_cells[3] = game_pkg::cell_of(lead_x, player.y);

	// ------------------------------------------------------------
	// next state
	// ------------------------------------------------------------
	always_comb begin
		player_next = player;

		// falling, or snap onto the brick top
		if (probe_solid[1:0] == 2'b00) begin
			player_next.y = y_probe;
			fall_upd = fall_next;
		end else begin
			player_next.y = ((y_probe >> game_pkg::TILE_SHIFT) << game_pkg::TILE_SHIFT) - 10'd1;
			fall_upd = '0;
		end

		// walking, flush against a wall when blocked
		x_target = player.x;
		if (go_right) begin
			player_next.face_left = 1'b0;
			if (|probe_solid[3:2])
				x_target = lead_edge - 10'd1 - player.scroll;
			else
				x_target = player.x + STEP;
		end else if (go_left) begin
			player_next.face_left = 1'b1;
			if (|probe_solid[3:2])
				x_target = lead_edge + TILE_W + LEFT_OFS - player.scroll;
			else
				x_target = player.x - STEP;
		end
		dx = game_pkg::vel_t'(x_target - player.x);

		// screen bounds turn the step into scroll
		if (x_target > game_pkg::SCREEN_MAX_X) begin
			player_next.x = game_pkg::SCREEN_MAX_X;
			player_next.scroll = player.scroll + game_pkg::coord_t'(dx);
		end else if (x_target - LEFT_OFS <= game_pkg::SCREEN_MIN_X) begin
			player_next.x = game_pkg::SCREEN_MIN_X + LEFT_OFS;
			player_next.scroll = player.scroll + game_pkg::coord_t'(dx);
		end else begin
			player_next.x = x_target;
		end
	end

	// one update per frame tick
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			player <= '{x: game_pkg::SPAWN_X, y: game_pkg::SPAWN_Y, scroll: '0, face_left: 1'b0};
			fall <= '0;
		end else if (frame_tick) begin
			player <= player_next;
			fall <= fall_upd;
		end
	end

endmodule

`default_nettype wire

/* logic/coin_tracker.sv */
`default_nettype none

module coin_tracker (
	input wire Clk,
	input wire Reset,
	input wire frame_tick,
	input wire game_pkg::player_state_t player,
	output logic [game_pkg::NUM_COINS-1:0] coin_present,
	output game_pkg::score_t score
);

	localparam game_pkg::coord_t LEFT_OFS = game_pkg::PLAYER_W - 10'd1;
	localparam game_pkg::coord_t TOP_OFS = game_pkg::PLAYER_H - 10'd1;

	game_pkg::coord_t wx_right;
	game_pkg::coord_t wx_left;
	game_pkg::tile_cell_t [3:0] corners;
	logic [game_pkg::NUM_COINS-1:0] clear;

	// corners in world space
	assign wx_right = player.x + player.scroll;
	assign wx_left = wx_right - LEFT_OFS;
	assign corners[0] = game_pkg::cell_of(wx_left, player.y - TOP_OFS);
	assign corners[1] = game_pkg::cell_of(wx_right, player.y - TOP_OFS);
	assign corners[2] = game_pkg::cell_of(wx_left, player.y);
	assign corners[3] = game_pkg::cell_of(wx_right, player.y);

	// first present coin touched by any corner
	always_comb begin
		logic found;
		found = 1'b0;
		clear = '0;
		for (int i = 0; i < game_pkg::NUM_COINS; i++) begin
			for (int c = 0; c < 4; c++) begin
				if (!found && coin_present[i] && corners[c] == game_pkg::COIN_CELLS[i]) begin
					clear[i] = 1'b1;
					found = 1'b1;
				end
			end
		end
	end

	// score counts cleared coins
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			coin_present <= '1;
			score <= '0;
		end else if (frame_tick && |clear) begin
			coin_present <= coin_present & ~clear;
			score <= score + 2'd1;
		end
	end

endmodule

`default_nettype wire

/* logic/pixel_renderer.sv */
`default_nettype none

module pixel_renderer (
	input wire Clk,
	input wire Reset,
	input wire video_pkg::pixel_req_t pix_req,
	input wire pix_req_valid,
	input wire game_pkg::player_state_t player,
	output game_pkg::tile_cell_t render_cell,
	input wire game_pkg::tile_kind_t render_kind,
	output video_pkg::pixel_out_t pix_out
);

	// box extents, widened so x - 25 cannot wrap
	localparam logic [10:0] LEFT_OFS = {1'b0, game_pkg::PLAYER_W - 10'd1};
	localparam logic [10:0] TOP_OFS = {1'b0, game_pkg::PLAYER_H - 10'd1};

	game_pkg::coord_t world_x;
	logic in_box;
	video_pkg::rgb_t rgb_next;
	video_pkg::rgb_t rgb_q;
	logic valid_q;

	// tile under the pixel, after scroll
	assign world_x = pix_req.draw_x + player.scroll;
	assign render_cell = game_pkg::cell_of(world_x, pix_req.draw_y);

	assign in_box = ({1'b0, pix_req.draw_x} + LEFT_OFS >= {1'b0, player.x}) &&
		(pix_req.draw_x <= player.x) &&
		({1'b0, pix_req.draw_y} + TOP_OFS >= {1'b0, player.y}) &&
		(pix_req.draw_y <= player.y);

	// ------------------------------------------------------------
	// colour pick
	// ------------------------------------------------------------
	always_comb begin
		if (!pix_req.active) begin
			rgb_next = video_pkg::COLOR_BLANK;
		end else if (in_box) begin
			// player drawn over the map
			rgb_next = video_pkg::COLOR_PLAYER;
		end else begin
			case (render_kind)
				game_pkg::TILE_BRICK: rgb_next = video_pkg::COLOR_BRICK;
				game_pkg::TILE_COIN: rgb_next = video_pkg::COLOR_COIN;
				default: rgb_next = video_pkg::COLOR_SKY;
			endcase
		end
	end

	// one cycle latency, valid strobe only
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset)
			valid_q <= 1'b0;
		else
			valid_q <= pix_req_valid;
	end

	always_ff @(posedge Clk) begin
		if (pix_req_valid)
			rgb_q <= rgb_next;
	end

	assign pix_out = '{rgb: rgb_q, valid: valid_q};

endmodule

`default_nettype wire

/* logic/platformer_top.sv */
`default_nettype none

module platformer_top #(
	parameter int max_vx = 4,
	parameter int terminal_fall = 6
) (
	input wire Clk,
	input wire Reset,
	input wire frame_tick,
	input wire game_pkg::key_t key,
	input wire video_pkg::pixel_req_t pix_req,
	input wire pix_req_valid,
	output game_pkg::player_state_t player,
	output game_pkg::score_t score,
	output video_pkg::pixel_out_t pix_out
);

	// map lookups
	game_pkg::tile_cell_t [3:0] probe_cells;
	logic [3:0] probe_solid;
	game_pkg::tile_cell_t render_cell;
	game_pkg::tile_kind_t render_kind;
	logic [game_pkg::NUM_COINS-1:0] coin_present;

	level_map i_level_map (
		.coin_present(coin_present),
		.probe_cells(probe_cells),
		.probe_solid(probe_solid),
		.render_cell(render_cell),
		.render_kind(render_kind)
	);

	player_motion #(
		.max_vx(max_vx),
		.terminal_fall(terminal_fall)
	) i_player_motion (
		.Clk(Clk),
		.Reset(Reset),
		.frame_tick(frame_tick),
		.key(key),
		.probe_cells(probe_cells),
		.probe_solid(probe_solid),
		.player(player)
	);

	// sees the player state from before the tick
	coin_tracker i_coin_tracker (
		.Clk(Clk),
		.Reset(Reset),
		.frame_tick(frame_tick),
		.player(player),
		.coin_present(coin_present),
		.score(score)
	);

	pixel_renderer i_pixel_renderer (
		.Clk(Clk),
		.Reset(Reset),
		.pix_req(pix_req),
		.pix_req_valid(pix_req_valid),
		.player(player),
		.render_cell(render_cell),
		.render_kind(render_kind),
		.pix_out(pix_out)
	);

endmodule

`default_nettype wire

/* tb/platformer_asserts.sv */
`default_nettype none

module platformer_asserts (
	input wire Clk,
	input wire Reset,
	input wire frame_tick,
	input wire pix_req_valid,
	input wire game_pkg::player_state_t player,
	input wire game_pkg::score_t score,
	input wire [game_pkg::NUM_COINS-1:0] coin_present,
	input wire video_pkg::pixel_out_t pix_out
);

	// coins only ever get cleared
	score_no_drop: assert property (@(posedge Clk) disable iff (Reset)
		score >= $past(score)) else $error("score decreased");

	// score is the number of coins already taken
	score_bounded: assert property (@(posedge Clk) disable iff (Reset)
		score == game_pkg::score_t'(game_pkg::NUM_COINS - $countones(coin_present)))
		else $error("score does not match the cleared coins");

	// fixed one cycle pixel latency
	pix_latency: assert property (@(posedge Clk) disable iff (Reset)
		pix_out.valid == $past(pix_req_valid)) else $error("pixel valid out of step");

	// y only moves on a frame update
	y_on_tick: assert property (@(posedge Clk) disable iff (Reset)
		$changed(player.y) |-> $past(frame_tick)) else $error("y moved without a tick");

endmodule

bind platformer_top platformer_asserts i_platformer_asserts (
	.Clk(Clk),
	.Reset(Reset),
	.frame_tick(frame_tick),
	.pix_req_valid(pix_req_valid),
	.player(player),
	.score(score),
	.coin_present(coin_present),
	.pix_out(pix_out)
);

`default_nettype wire

/* tb/platformer_tb.sv */
`default_nettype none

module platformer_tb;

	// wide enough steps that the spawn fall can pass through the first coin
	localparam int STEP_X = 8;
	localparam int FALL_CAP = 6;
	localparam int IDLE_CYCLES = 3;

	logic Clk;
	logic Reset;
	logic frame_tick;
	game_pkg::key_t key;
	video_pkg::pixel_req_t pix_req;
	logic pix_req_valid;
	game_pkg::player_state_t player;
	game_pkg::score_t score;
	video_pkg::pixel_out_t pix_out;

	int watch_cycles = 0;

	platformer_top #(
		.max_vx(STEP_X),
		.terminal_fall(FALL_CAP)
	) i_platformer_top (
		.Clk(Clk),
		.Reset(Reset),
		.frame_tick(frame_tick),
		.key(key),
		.pix_req(pix_req),
		.pix_req_valid(pix_req_valid),
		.player(player),
		.score(score),
		.pix_out(pix_out)
	);

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_player(input game_pkg::player_state_t got,
		input game_pkg::player_state_t exp);
		if (got !== exp) begin
			$display("ERR %0t: player x=%0d y=%0d scroll=%0d face_left=%0b", $time,
				got.x, got.y, got.scroll, got.face_left);
			$display("ERR %0t: expected x=%0d y=%0d scroll=%0d face_left=%0b", $time,
				exp.x, exp.y, exp.scroll, exp.face_left);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_score(input game_pkg::score_t got, input game_pkg::score_t exp);
		if (got !== exp) begin
			$display("ERR %0t: score %0d, expected %0d", $time, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_rgb(input video_pkg::rgb_t got, input video_pkg::rgb_t exp);
		if (got !== exp) begin
			$display("ERR %0t: pixel colour %06h, expected %06h", $time, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// ------------------------------------------------------------
	// drivers on the falling edge
	// ------------------------------------------------------------
	task automatic apply_reset();
		Reset = 1'b1;
		repeat (10) @(negedge Clk);
		Reset = 1'b0;
	endtask

	// one tick pulse per frame with idle cycles between
	task automatic run_frames(input game_pkg::key_t k, input int n);
		key = k;
		for (int i = 0; i < n; i++) begin
			frame_tick = 1'b1;
			@(negedge Clk);
			frame_tick = 1'b0;
			repeat (IDLE_CYCLES) @(negedge Clk);
		end
	endtask

	// registered result shows up one edge later
	task automatic request_pixel(input int dx, input int dy, input int act,
		output video_pkg::pixel_out_t res);
		pix_req = '{draw_x: game_pkg::coord_t'(dx), draw_y: game_pkg::coord_t'(dy),
			active: act[0]};
		pix_req_valid = 1'b1;
		@(negedge Clk);
		res = pix_out;
		pix_req_valid = 1'b0;
		@(negedge Clk);
	endtask

	// ------------------------------------------------------------
	// stimulus file
	// ------------------------------------------------------------
	initial begin
		int fd;
		int frames_total;
		int pixel_lines;
		int fields;
		int k;
		int n;
		int ex;
		int ey;
		int es;
		int esc;
		int act;
		logic [23:0] exp_rgb;
		logic exp_face;
		string line;
		game_pkg::player_state_t exp_player;
		video_pkg::pixel_out_t res;

		Reset = 1'b1;
		frame_tick = 1'b0;
		key = '0;
		pix_req = '0;
		pix_req_valid = 1'b0;
		frames_total = 0;
		pixel_lines = 0;
		exp_face = 1'b0;

		// first pass sizes the watchdog
		fd = $fopen("tb/platformer_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file tb/platformer_stimulus.txt");
			$display("Testbench failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) == "F") begin
				if ($sscanf(line, "F %h %d", k, n) == 2)
					frames_total += n;
			end else if (line.len() > 0 && line.getc(0) == "P") begin
				pixel_lines++;
			end
		end
		$fclose(fd);
		watch_cycles = frames_total * 10 + pixel_lines + 100;

		fd = $fopen("tb/platformer_stimulus.txt", "r");
		@(negedge Clk);
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) == "R") begin
				apply_reset();
				exp_face = 1'b0;
			end else if (line.len() > 0 && line.getc(0) == "F") begin
				fields = $sscanf(line, "F %h %d %d %d %d %d", k, n, ex, ey, es, esc);
				if (fields != 6) begin
					$display("frame line in the stimulus file is malformed: %s", line);
					$display("Testbench failed");
					$fatal(1);
				end
				run_frames(game_pkg::key_t'(k), n);
				// facing follows the last key that moved
				if (n > 0 && game_pkg::key_t'(k) == game_pkg::KEY_RIGHT)
					exp_face = 1'b0;
				else if (n > 0 && game_pkg::key_t'(k) == game_pkg::KEY_LEFT)
					exp_face = 1'b1;
				exp_player = '{x: game_pkg::coord_t'(ex), y: game_pkg::coord_t'(ey),
					scroll: game_pkg::coord_t'(es), face_left: exp_face};
				check_player(player, exp_player);
				check_score(score, game_pkg::score_t'(esc));
			end else if (line.len() > 0 && line.getc(0) == "P") begin
				fields = $sscanf(line, "P %d %d %d %h", ex, ey, act, exp_rgb);
				if (fields != 4) begin
					$display("pixel line in the stimulus file is malformed: %s", line);
					$display("Testbench failed");
					$fatal(1);
				end
				request_pixel(ex, ey, act, res);
				if (res.valid !== 1'b1) begin
					$display("pixel result valid did not rise one cycle after the request");
					$display("Testbench failed");
					$fatal(1);
				end
				check_rgb(res.rgb, exp_rgb);
			end
		end
		$fclose(fd);
		$display("Testbench passed");
		$finish;
	end

	// ------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------
	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge Clk);
		$display("the run timed out after %0d clock cycles", watch_cycles);
		$display("Testbench failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* tb/platformer_stimulus.txt */
# F key(hex) frames x y scroll score : run the frames, then expected player and score
# P draw_x draw_y active rgb(hex) : one pixel request and its expected colour
R
F 00 0 228 33 0 0
F 00 1 228 34 0 0
F 00 1 228 36 0 0
F 00 1 228 39 0 0
F 00 1 228 43 0 0
F 00 1 228 48 0 0
F 00 1 228 54 0 0
F 00 1 228 60 0 0
F 00 1 228 66 0 0
F 00 50 228 351 0 0
F 00 2 228 351 0 0
F 07 19 380 351 0 0
F 07 1 384 351 8 0
F 07 3 384 351 32 0
F 07 3 384 351 56 0
F 07 1 384 351 63 0
F 07 4 384 351 63 0
P 380 340 1 FF5500
P 380 340 0 000000
P 390 330 1 833D00
P 100 400 1 833D00
P 100 100 1 00007F
P 400 230 1 FFC107
R
F 00 0 228 33 0 0
F 00 10 228 78 0 0
F 07 19 380 192 0 0
F 07 1 384 198 8 0
F 07 7 384 240 64 0
F 07 1 384 246 72 1
F 07 1 384 252 80 1
P 400 250 1 00007F
P 580 200 1 FFC107

/* verilog.f */
logic/game_pkg.sv
logic/video_pkg.sv
logic/level_map.sv
logic/player_motion.sv
logic/coin_tracker.sv
logic/pixel_renderer.sv
logic/platformer_top.sv
tb/platformer_asserts.sv
tb/platformer_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -f verilog.f --top-module platformer_tb -Mdir obj_dir
	./obj_dir/Vplatformer_tb

clean:
	rm -rf obj_dir
